// File: verilog.f
+incdir+.
adcfifo_addr_pkg.sv
adcfifo_stream_pkg.sv
adcfifo_rel_xfer.sv
adcfifo_mem_asym.sv
adcfifo_wr_ctrl.sv
adcfifo_rd_ctrl.sv
adcfifo_dma.sv
adcfifo_dma_assert.sv
tb_adcfifo_dma.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_adcfifo_dma \
  -f verilog.f -o tb_adcfifo_dma
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_adcfifo_dma +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST PASSED" sim.log; then
  exit 0
fi
exit 1

// File: tb_adcfifo_dma.sv
/*
  Testbench of the ADC capture buffer. Writes LFSR data on axi_clk, reads
  the slices back on dma_clk against a model queue and prints one line per
  test followed by a summary and the verdict.
*/
`timescale 1ns/1ps
`default_nettype none

`include "adcfifo_cfg.svh"

module tb_adcfifo_dma;

  localparam int ORDER_WORDS = 40;
  localparam int BP_WORDS    = 60;
  localparam int DW          = `ADCFIFO_DMA_DW;
  localparam int RATIO       = `ADCFIFO_RATIO;
  localparam int TOTAL_WORDS = ORDER_WORDS + BP_WORDS + 2**`ADCFIFO_AXI_AW + 2;
  // Every narrow word gets up to four DMA periods of 10 ns, plus a margin
  localparam int WATCHDOG_NS = TOTAL_WORDS * RATIO * 10 * 4 + 20000;

  logic                             axi_clk = 1'b0;
  logic                             axi_drst = 1'b1;
  logic                             axi_dvalid = 1'b0;
  adcfifo_stream_pkg::axi_word_t    axi_ddata = '0;
  logic                             axi_dready;
  adcfifo_stream_pkg::xfer_status_t axi_xfer_status = '0;
  logic                             dma_clk = 1'b0;
  logic                             dma_xfer_req = 1'b0;
  logic                             dma_wready = 1'b0;
  logic                             dma_wr;
  adcfifo_stream_pkg::dma_word_t    dma_wdata;
  adcfifo_stream_pkg::xfer_status_t dma_xfer_status;

  logic [31:0]                   lfsr = 32'd2;
  adcfifo_stream_pkg::dma_word_t model[$];
  adcfifo_stream_pkg::dma_word_t exp_w;
  int                            err_cnt = 0;
  int                            chk_cnt = 0;
  // DMA ready mode is 0 for held high, 1 for random and 2 for held low
  int                            rdy_mode = 0;

  initial begin
    forever #4 axi_clk = ~axi_clk;
  end

  initial begin
    forever #5 dma_clk = ~dma_clk;
  end

  adcfifo_dma adcfifo_dma_inst (
    .axi_clk         (axi_clk),
    .axi_drst        (axi_drst),
    .axi_dvalid      (axi_dvalid),
    .axi_ddata       (axi_ddata),
    .axi_dready      (axi_dready),
    .axi_xfer_status (axi_xfer_status),
    .dma_clk         (dma_clk),
    .dma_xfer_req    (dma_xfer_req),
    .dma_wready      (dma_wready),
    .dma_wr          (dma_wr),
    .dma_wdata       (dma_wdata),
    .dma_xfer_status (dma_xfer_status)
  );

  // ********************************************************************
  // Random source and stimulus helpers
  // ********************************************************************

  // One Galois step per bit taken and the bit shifted out is the result
  function automatic logic next_bit();
    logic out;
    out  = lfsr[0];
    lfsr = out ? ((lfsr >> 1) ^ 32'hD0000001) : (lfsr >> 1);
    return out;
  endfunction

  function automatic adcfifo_stream_pkg::axi_word_t take_bits(input int n);
    adcfifo_stream_pkg::axi_word_t r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[$bits(r)-2:0], next_bit()};
    end
    return r;
  endfunction

  // Drives one wide word and queues its slices with the lowest slice first
  task automatic put_word();
    adcfifo_stream_pkg::axi_word_t w;
    w = take_bits($bits(w));
    axi_dvalid <= 1'b1;
    axi_ddata  <= w;
    for (int s = 0; s < RATIO; s++) begin
      model.push_back(w[s*DW +: DW]);
    end
  endtask

  task automatic write_words(input int n, input bit gaps);
    int acc;
    acc = 0;
    while (acc < n) begin
      @(posedge axi_clk);
      if (axi_dready && (!gaps || next_bit())) begin
        put_word();
        acc++;
      end else begin
        axi_dvalid <= 1'b0;
      end
    end
    @(posedge axi_clk);
    axi_dvalid <= 1'b0;
  endtask

  task automatic wait_ready();
    while (!axi_dready) begin
      @(posedge axi_clk);
    end
  endtask

  // Keeps writing until the buffer reports it is nearly full
  task automatic fill_until_stall(output int acc);
    acc = 0;
    wait_ready();
    @(posedge axi_clk);
    while (axi_dready) begin
      put_word();
      acc++;
      @(posedge axi_clk);
    end
    axi_dvalid <= 1'b0;
  endtask

  // The model only changes on the rising edge, so it is looked at on the falling one
  task automatic wait_drain();
    while (model.size() != 0) begin
      @(negedge dma_clk);
    end
  endtask

  task automatic print_result(input string name, input int e0, input int c0);
    $display("test %s: %0d words checked, %0d errors", name, chk_cnt - c0, err_cnt - e0);
  endtask

  always @(posedge dma_clk) begin
    case (rdy_mode)
      0: dma_wready <= 1'b1;
      1: dma_wready <= next_bit();
      default: dma_wready <= 1'b0;
    endcase
  end

  // Every accepted beat is compared with the oldest slice in the model
  always @(posedge dma_clk) begin
    if (dma_wr && dma_wready) begin
      chk_cnt++;
      assert (model.size() != 0) else begin
        $display("A word was accepted at %0t with nothing left to expect", $time);
        err_cnt++;
      end
      if (model.size() != 0) begin
        exp_w = model.pop_front();
        assert (dma_wdata == exp_w) else begin
          $display("ERR dma_wdata expected %h actual %h", exp_w, dma_wdata);
          err_cnt++;
        end
      end
    end
  end

  // ********************************************************************
  // Test sequence
  // ********************************************************************

  initial begin
    int e0;
    int c0;
    int acc;
    int n;
    int fails;
    repeat (2) @(posedge axi_clk);
    axi_drst <= 1'b0;

    e0 = err_cnt;
    c0 = chk_cnt;
    repeat (4) @(posedge dma_clk);
    print_result("reset", e0, c0);
    dma_xfer_req <= 1'b1;
    repeat (4) @(posedge dma_clk);

    e0 = err_cnt;
    c0 = chk_cnt;
    rdy_mode <= 0;
    write_words(ORDER_WORDS, 1'b0);
    wait_drain();
    print_result("order", e0, c0);

    e0 = err_cnt;
    c0 = chk_cnt;
    rdy_mode <= 1;
    write_words(BP_WORDS, 1'b1);
    wait_drain();
    print_result("backpressure", e0, c0);

    // The reader is stalled so the fill climbs to the high mark
    e0 = err_cnt;
    c0 = chk_cnt;
    rdy_mode <= 2;
    fill_until_stall(acc);
    assert (acc * RATIO <= 2**`ADCFIFO_DMA_AW) else begin
      $display("Buffer took %0d narrow words before axi_dready fell", acc * RATIO);
      err_cnt++;
    end
    rdy_mode <= 0;
    wait_drain();
    wait_ready();
    print_result("hysteresis", e0, c0);

    e0 = err_cnt;
    c0 = chk_cnt;
    @(posedge axi_clk);
    axi_xfer_status <= 4'h9;
    rdy_mode <= 1;
    write_words(2, 1'b0);
    n = 0;
    do begin
      @(posedge dma_clk);
      n++;
    end while (dma_xfer_status != 4'h9 && n < 64);
    assert (dma_xfer_status == 4'h9) else begin
      $display("ERR dma_xfer_status expected %h actual %h", 4'h9, dma_xfer_status);
      err_cnt++;
    end
    do begin
      @(posedge dma_clk);
    end while (!dma_wr && model.size() != 0);
    dma_xfer_req <= 1'b0;
    rdy_mode <= 2;
    repeat (3) @(posedge dma_clk);
    model.delete();
    print_result("status", e0, c0);

    fails = err_cnt + adcfifo_dma_inst.dma_assert_inst.fail_cnt;
    $display("summary: 5 tests, %0d words checked, %0d errors, %0d assertion failures",
             chk_cnt, err_cnt, adcfifo_dma_inst.dma_assert_inst.fail_cnt);
    if (fails == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: adcfifo_dma_assert.sv
/*
  Concurrent checks on the ports of the capture buffer. The module is
  attached to every instance of the top level by the bind at the end.
*/
`timescale 1ns/1ps
`default_nettype none

module adcfifo_dma_assert (
  input wire                                   axi_clk,
  input wire                                   axi_drst,
  input wire                                   axi_dready,
  input wire                                   dma_clk,
  input wire                                   dma_xfer_req,
  input wire                                   dma_wready,
  input wire                                   dma_wr,
  input wire adcfifo_stream_pkg::dma_word_t    dma_wdata,
  input wire adcfifo_stream_pkg::xfer_status_t dma_xfer_status
);

  // A drained buffer brings ready back well inside this many axi_clk cycles
  localparam int unsigned READY_LIMIT = 2048;

  int unsigned low_cnt;
  int          fail_cnt = 0;

  function automatic void note_fail(input string what);
    fail_cnt++;
    $error("%s", what);
  endfunction

  // Length of the current stretch with axi_dready low
  always_ff @(posedge axi_clk) begin
    if (axi_drst || axi_dready) begin
      low_cnt <= 0;
    end else begin
      low_cnt <= low_cnt + 1;
    end
  end

  a_rst_ready: assert property (@(posedge axi_clk) axi_drst |=> !axi_dready)
    else note_fail("axi_dready is high after reset");

  a_idle_wr: assert property (@(posedge dma_clk) !dma_xfer_req |=> !dma_wr)
    else note_fail("dma_wr is high without a transfer request");

  a_idle_status: assert property (@(posedge dma_clk)
    !dma_xfer_req |=> dma_xfer_status == '0)
    else note_fail("dma_xfer_status is not cleared without a transfer request");

  // A stalled beat keeps its data until the DMA takes it
  a_wdata_hold: assert property (@(posedge dma_clk) disable iff (!dma_xfer_req)
    dma_wr && !dma_wready |=> dma_wr && $stable(dma_wdata))
    else note_fail("dma_wdata changed while the DMA stalled");

  a_ready_back: assert property (@(posedge axi_clk) disable iff (axi_drst)
    low_cnt < READY_LIMIT)
    else note_fail("axi_dready did not rise again after falling");

endmodule

bind adcfifo_dma adcfifo_dma_assert dma_assert_inst (.*);

`default_nettype wire

// File: adcfifo_dma.sv
/*
  Top level of the ADC capture buffer. Joins the write controller on
  axi_clk and the read controller on dma_clk through the asymmetric memory
  and three periodic crossings for positions and status.
*/
`timescale 1ns/1ps
`default_nettype none

module adcfifo_dma (
  input  wire                                axi_clk,
  input  wire                                axi_drst,
  input  wire                                axi_dvalid,
  input  wire adcfifo_stream_pkg::axi_word_t axi_ddata,
  output logic                               axi_dready,
  input  wire adcfifo_stream_pkg::xfer_status_t axi_xfer_status,
  input  wire                                dma_clk,
  input  wire                                dma_xfer_req,
  input  wire                                dma_wready,
  output logic                               dma_wr,
  output adcfifo_stream_pkg::dma_word_t      dma_wdata,
  output adcfifo_stream_pkg::xfer_status_t   dma_xfer_status
);

  logic                          dma_rst;
  adcfifo_addr_pkg::waddr_t      axi_waddr;
  adcfifo_addr_pkg::raddr_t      axi_raddr_rel;
  adcfifo_addr_pkg::waddr_t      dma_waddr_rel;
  adcfifo_addr_pkg::raddr_t      dma_raddr;
  adcfifo_stream_pkg::dma_word_t dma_rdata;

  // The read side is held clear whenever no transfer is requested
  assign dma_rst = ~dma_xfer_req;

  adcfifo_wr_ctrl wr_ctrl_inst (
    .axi_clk    (axi_clk),
    .axi_drst   (axi_drst),
    .axi_dvalid (axi_dvalid),
    .waddr      (axi_waddr),
    .rd_rel     (axi_raddr_rel),
    .axi_dready (axi_dready)
  );

  adcfifo_rd_ctrl rd_ctrl_inst (
    .dma_clk      (dma_clk),
    .dma_xfer_req (dma_xfer_req),
    .wr_rel       (dma_waddr_rel),
    .dma_wready   (dma_wready),
    .raddr        (dma_raddr),
    .rd_data      (dma_rdata),
    .dma_wr       (dma_wr),
    .dma_wdata    (dma_wdata)
  );

  adcfifo_mem_asym mem_inst (
    .axi_clk (axi_clk),
    .wr_en   (axi_dvalid),
    .wr_addr (axi_waddr),
    .wr_data (axi_ddata),
    .dma_clk (dma_clk),
    .rd_addr (dma_raddr),
    .rd_data (dma_rdata)
  );

  // ********************************************************************
  // Clock-domain crossings
  // ********************************************************************

  adcfifo_rel_xfer #(.payload_t(adcfifo_addr_pkg::waddr_t)) rel_w (
    .src_clk  (axi_clk),
    .src_rst  (axi_drst),
    .src_data (axi_waddr),
    .dst_clk  (dma_clk),
    .dst_rst  (dma_rst),
    .dst_data (dma_waddr_rel)
  );

  adcfifo_rel_xfer #(.payload_t(adcfifo_addr_pkg::raddr_t)) rel_r (
    .src_clk  (dma_clk),
    .src_rst  (dma_rst),
    .src_data (dma_raddr),
    .dst_clk  (axi_clk),
    .dst_rst  (axi_drst),
    .dst_data (axi_raddr_rel)
  );

  adcfifo_rel_xfer #(.payload_t(adcfifo_stream_pkg::xfer_status_t)) rel_s (
    .src_clk  (axi_clk),
    .src_rst  (axi_drst),
    .src_data (axi_xfer_status),
    .dst_clk  (dma_clk),
    .dst_rst  (dma_rst),
    .dst_data (dma_xfer_status)
  );

endmodule

`default_nettype wire

// File: adcfifo_rd_ctrl.sv
/*
  Read-side control on dma_clk. Issues narrow reads while written data is
  available, tracks them through the memory latency and hands them to the
  DMA from a small queue. Everything clears while dma_xfer_req is low.
*/
`timescale 1ns/1ps
`default_nettype none

`include "adcfifo_cfg.svh"

module adcfifo_rd_ctrl (
  input  wire                            dma_clk,
  input  wire                            dma_xfer_req,
  input  wire adcfifo_addr_pkg::waddr_t  wr_rel,
  input  wire                            dma_wready,
  output adcfifo_addr_pkg::raddr_t       raddr,
  input  wire adcfifo_stream_pkg::dma_word_t rd_data,
  output logic                           dma_wr,
  output adcfifo_stream_pkg::dma_word_t  dma_wdata
);

  localparam int unsigned SHIFT  = $clog2(`ADCFIFO_RATIO);
  localparam int unsigned QDEPTH = 4;

  logic                          clr;
  logic                          wready_s;
  logic                          avail;
  logic                          issue;
  logic                          pop;
  logic [2:0]                    occ;
  logic [2:0]                    in_use;
  logic                          rd_v1;
  adcfifo_stream_pkg::dma_beat_t rd_s2;
  adcfifo_stream_pkg::dma_beat_t q [QDEPTH];
  logic [$clog2(QDEPTH)-1:0]     q_wp;
  logic [$clog2(QDEPTH)-1:0]     q_rp;

  assign clr      = ~dma_xfer_req;
  assign wready_s = (`ADCFIFO_DMA_READY_ENABLE == 0) ? 1'b1 : dma_wready;
  assign avail    = (raddr != {wr_rel, {SHIFT{1'b0}}});

  // Queue occupancy is the number of entries with their valid bit set
  always_comb begin
    occ = '0;
    for (int i = 0; i < QDEPTH; i++) begin
      occ = occ + 3'(q[i].valid);
    end
  end

  // Words in the queue plus the ones still coming out of the memory
  assign in_use = occ + rd_v1 + rd_s2.valid;
  assign issue  = avail && wready_s && (in_use < 3'(QDEPTH));

  assign dma_wr    = q[q_rp].valid;
  assign dma_wdata = q[q_rp].data;
  assign pop       = dma_wr && wready_s;

  always_ff @(posedge dma_clk) begin
    rd_s2.data <= rd_data;
    if (clr) begin
      raddr       <= '0;
      rd_v1       <= 1'b0;
      rd_s2.valid <= 1'b0;
      q_wp        <= '0;
      q_rp        <= '0;
      for (int i = 0; i < QDEPTH; i++) begin
        q[i].valid <= 1'b0;
      end
    end else begin
      if (issue) begin
        raddr <= raddr + 1'b1;
      end
      // Stage one lines up with the memory output, stage two with rd_s2
      rd_v1       <= issue;
      rd_s2.valid <= rd_v1;
      if (pop) begin
        q[q_rp].valid <= 1'b0;
        q_rp          <= q_rp + 1'b1;
      end
      if (rd_s2.valid) begin
        q[q_wp] <= rd_s2;
        q_wp    <= q_wp + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: adcfifo_wr_ctrl.sv
/*
  Write-side control on axi_clk. Advances the wide write address on every
  valid word and derives the advisory ready flag from the buffer fill.
*/
`timescale 1ns/1ps
`default_nettype none

`include "adcfifo_cfg.svh"

module adcfifo_wr_ctrl (
  input  wire                           axi_clk,
  input  wire                           axi_drst,
  input  wire                           axi_dvalid,
  output adcfifo_addr_pkg::waddr_t      waddr,
  input  wire adcfifo_addr_pkg::raddr_t rd_rel,
  output logic                          axi_dready
);

  localparam int unsigned SHIFT = $clog2(`ADCFIFO_RATIO);

  adcfifo_addr_pkg::raddr_t wpos;
  adcfifo_addr_pkg::fill_t  fill;

  // Write position expressed in narrow words
  assign wpos = {waddr, {SHIFT{1'b0}}};

  // ********************************************************************
  // Write address
  // ********************************************************************

  // Words are never refused, so the address follows axi_dvalid alone
  always_ff @(posedge axi_clk) begin
    if (axi_drst) begin
      waddr <= '0;
    end else if (axi_dvalid) begin
      waddr <= waddr + 1'b1;
    end
  end

  // ********************************************************************
  // Fill and ready hysteresis
  // ********************************************************************

  // The released read address lags the reader, so the fill errs high
  always_ff @(posedge axi_clk) begin
    if (axi_drst) begin
      fill       <= '0;
      axi_dready <= 1'b0;
    end else begin
      fill <= adcfifo_addr_pkg::fill_t'(wpos - rd_rel);
      if (fill >= `ADCFIFO_HI_MARK) begin
        axi_dready <= 1'b0;
      end else if (fill <= `ADCFIFO_LO_MARK) begin
        axi_dready <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: adcfifo_mem_asym.sv
/*
  Dual-clock buffer memory. Written one wide word at a time on axi_clk and
  read one narrow slice at a time on dma_clk with a registered output.
*/
`timescale 1ns/1ps
`default_nettype none

`include "adcfifo_cfg.svh"

module adcfifo_mem_asym (
  input  wire                           axi_clk,
  input  wire                           wr_en,
  input  wire adcfifo_addr_pkg::waddr_t wr_addr,
  input  wire adcfifo_stream_pkg::axi_word_t wr_data,
  input  wire                           dma_clk,
  input  wire adcfifo_addr_pkg::raddr_t rd_addr,
  output adcfifo_stream_pkg::dma_word_t rd_data
);

  localparam int unsigned SHIFT = $clog2(`ADCFIFO_RATIO);
  localparam int unsigned DW = $bits(adcfifo_stream_pkg::dma_word_t);

  adcfifo_stream_pkg::axi_word_t mem [2**`ADCFIFO_AXI_AW];
  adcfifo_addr_pkg::waddr_t      rd_word;
  logic [SHIFT-1:0]              rd_sel;

  // Upper narrow address bits pick the wide word, lower bits the slice
  assign rd_word = rd_addr[`ADCFIFO_DMA_AW-1:SHIFT];
  assign rd_sel  = rd_addr[SHIFT-1:0];

  always_ff @(posedge axi_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Slice 0 sits in the least significant bits of the wide word
  always_ff @(posedge dma_clk) begin
    rd_data <= mem[rd_word][rd_sel*DW +: DW];
  end

endmodule

`default_nettype wire

// File: adcfifo_rel_xfer.sv
/*
  Periodic toggle crossing. The source samples its payload at a fixed
  interval and flips a toggle; the destination loads the held copy once
  the synchronized toggle shows an edge.
*/
`timescale 1ns/1ps
`default_nettype none

`include "adcfifo_cfg.svh"

module adcfifo_rel_xfer #(
  parameter type payload_t = logic
) (
  input  wire      src_clk,
  input  wire      src_rst,
  input  wire      payload_t src_data,
  input  wire      dst_clk,
  input  wire      dst_rst,
  output payload_t dst_data
);

  localparam int unsigned PERIOD_W = `ADCFIFO_REL_PERIOD_LOG2;

  logic [PERIOD_W-1:0] rel_cnt;
  logic                src_tgl;
  payload_t            src_hold;
  logic [2:0]          dst_sync;

  // Source side. The held copy stays put for a whole release period
  always_ff @(posedge src_clk) begin
    if (src_rst) begin
      rel_cnt  <= '0;
      src_tgl  <= 1'b0;
      src_hold <= '0;
    end else begin
      rel_cnt <= rel_cnt + 1'b1;
      if (&rel_cnt) begin
        src_tgl  <= ~src_tgl;
        src_hold <= src_data;
      end
    end
  end

  // Destination side, the first flop absorbs metastability
  always_ff @(posedge dst_clk) begin
    if (dst_rst) begin
      dst_sync <= '0;
      dst_data <= '0;
    end else begin
      dst_sync <= {dst_sync[1:0], src_tgl};
      if (dst_sync[2] ^ dst_sync[1]) begin
        dst_data <= src_hold;
      end
    end
  end

endmodule

`default_nettype wire

// File: adcfifo_stream_pkg.sv
/*
  Data types of the capture stream: the wide ADC word, the narrow DMA
  slice, the transfer status and the beat held in the output queue.
*/
`default_nettype none

`include "adcfifo_cfg.svh"

package adcfifo_stream_pkg;

  typedef logic [`ADCFIFO_AXI_DW-1:0] axi_word_t;

  typedef logic [`ADCFIFO_DMA_DW-1:0] dma_word_t;

  // Status bits are passed through from the ADC side untouched
  typedef logic [3:0] xfer_status_t;

  // One entry of the read-side holding queue
  typedef struct packed {
    logic      valid;
    dma_word_t data;
  } dma_beat_t;

endpackage

`default_nettype wire

// File: adcfifo_addr_pkg.sv
/*
  Address and fill types shared by the controllers, the memory and the
  clock-domain crossings of the capture buffer.
*/
`default_nettype none

`include "adcfifo_cfg.svh"

package adcfifo_addr_pkg;

  // Wide word position on the write side
  typedef logic [`ADCFIFO_AXI_AW-1:0] waddr_t;

  // Narrow word position on the read side
  typedef logic [`ADCFIFO_DMA_AW-1:0] raddr_t;

  // Buffer occupancy in narrow words, wraps with the read address
  typedef logic [`ADCFIFO_DMA_AW-1:0] fill_t;

endpackage

`default_nettype wire

// File: adcfifo_cfg.svh
/*
  Build-time configuration of the ADC capture buffer.
  Include this header wherever a width, depth, threshold or mode is needed.
*/
`ifndef ADCFIFO_CFG_SVH
`define ADCFIFO_CFG_SVH

// Data path widths, the narrow side must divide the wide side
`define ADCFIFO_AXI_DW 128
`define ADCFIFO_DMA_DW 32
`define ADCFIFO_RATIO 4

// Buffer depth is 256 narrow words, or 64 wide words at a ratio of 4
`define ADCFIFO_DMA_AW 8
`define ADCFIFO_AXI_AW 6

// Ready hysteresis, counted in narrow words of fill
`define ADCFIFO_HI_MARK 180
`define ADCFIFO_LO_MARK 8

// Positions cross the clock boundary once every 2**N source cycles
`define ADCFIFO_REL_PERIOD_LOG2 3

// Set to 0 when the DMA sink can always take data
`define ADCFIFO_DMA_READY_ENABLE 1

`endif
